// ==== bench/icacheChecker.sv ====
`timescale 1ns/1ns

module icacheChecker (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic fetchReq,
    input  logic [31:0] fetchAddr,
    input  logic fetchAck,
    input  logic [31:0] fetchData,
    input  logic memReq,
    input  logic [31:0] memAddr,
    input  logic expectMiss,
    input  logic [7:0] testNum,
    input  logic testEnd,
    output int errorCount,
    output int testCount,
    output int testFailCount
);

    // reference model of the cache state
    logic [21:0] tagM [64][4];
    logic [3:0] validM [64];
    logic [2:0] ageM [64];

    bit busy;
    bit ackSeen;
    bit memSeen;
    bit predMiss;
    logic [31:0] reqAddr;
    logic [31:0] predData;
    int cycle;
    int reqCycle;
    int errors;
    int tests;
    int testsFailed;
    int testErrors;
    int fetchCount;

    assign errorCount = errors;
    assign testCount = tests;
    assign testFailCount = testsFailed;

    function automatic logic [31:0] memWord(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ 32'h5A5A0000;
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
        $display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
        errors++;
        testErrors++;
    endtask

    task automatic reportProblem(input string msg);
        $display("problem at %0t ns: %s", $time, msg);
        errors++;
        testErrors++;
    endtask

    task automatic clearModel();
        for (int s = 0; s < 64; s++) begin
            validM[s] = '0;
            ageM[s] = '0;
        end
    endtask

    // lowest empty way first, then the age tree
    function automatic int victimOf(input int idx);
        logic [2:0] a;
        a = ageM[idx];
        for (int w = 0; w < 4; w++) begin
            if (!validM[idx][w]) begin
                return w;
            end
        end
        if (!a[2] && !a[0]) begin
            return 0;
        end else if (!a[2]) begin
            return 1;
        end else if (!a[1]) begin
            return 2;
        end
        return 3;
    endfunction

    task automatic touch(input int idx, input int way);
        case (way)
            0: begin
                ageM[idx][2] = 1'b1;
                ageM[idx][0] = 1'b1;
            end
            1: begin
                ageM[idx][2] = 1'b1;
                ageM[idx][0] = 1'b0;
            end
            2: begin
                ageM[idx][2] = 1'b0;
                ageM[idx][1] = 1'b1;
            end
            default: begin
                ageM[idx][2] = 1'b0;
                ageM[idx][1] = 1'b0;
            end
        endcase
    endtask

    task automatic predictFetch(input logic [31:0] a);
        int idx;
        int way;
        bit found;
        logic [21:0] t;
        idx = int'(a[9:4]);
        t = a[31:10];
        found = 0;
        way = 0;
        for (int w = 3; w >= 0; w--) begin
            if (validM[idx][w] && tagM[idx][w] == t) begin
                found = 1;
                way = w;
            end
        end
        if (!found) begin
            way = victimOf(idx);
            tagM[idx][way] = t;
            validM[idx][way] = 1'b1;
        end
        touch(idx, way);
        predMiss = !found;
        predData = memWord(a);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            clearModel();
            busy = 0;
            ackSeen = 0;
            memSeen = 0;
            cycle = 0;
        end else begin
            cycle++;
            if (flush && !fetchReq && !busy) begin
                clearModel();
            end
            if (!busy) begin
                if (fetchReq) begin
                    busy = 1;
                    ackSeen = 0;
                    memSeen = 0;
                    reqAddr = fetchAddr;
                    reqCycle = cycle;
                    fetchCount++;
                    predictFetch(fetchAddr);
                    if (predMiss != expectMiss) begin
                        reportProblem("reference model and stimulus table disagree on the miss");
                    end
                end else if (fetchAck || memReq) begin
                    reportProblem("fetchAck or memReq is high with no fetch in flight");
                end
            end else begin
                if (memReq && ackSeen) begin
                    reportProblem("memReq is high after fetchAck");
                end else if (memReq && !memSeen) begin
                    memSeen = 1;
                    if (memAddr != {reqAddr[31:4], 4'b0000}) begin
                        reportMismatch("memAddr", {reqAddr[31:4], 4'b0000}, memAddr);
                    end
                end
                if (fetchAck && !ackSeen) begin
                    ackSeen = 1;
                    if (fetchData != predData) begin
                        reportMismatch("fetchData", predData, fetchData);
                    end
                    if (memSeen != predMiss) begin
                        reportMismatch("memReq before fetchAck", 32'(predMiss), 32'(memSeen));
                    end
                    // ack is set at edge N+2, so it is first sampled at N+3
                    if (!predMiss && cycle - reqCycle != 3) begin
                        reportMismatch("hit latency", 32'd3, 32'(cycle - reqCycle));
                    end
                end else if (ackSeen && !fetchAck) begin
                    busy = 0;
                end
            end
            if (testEnd) begin
                tests++;
                if (testErrors == 0) begin
                    $display("test %0d passed after %0d fetches", testNum, fetchCount);
                end else begin
                    $display("test %0d failed with %0d errors", testNum, testErrors);
                    testsFailed++;
                end
                testErrors = 0;
                fetchCount = 0;
            end
        end
    end

endmodule

// ==== bench/icacheProperties_properties.sv ====
`timescale 1ns/1ns

module icacheProperties (
    input  logic clk,
    input  logic rst,
    input  logic fetchReq,
    input  logic [31:0] fetchAddr,
    input  logic fetchAck,
    input  logic memReq,
    input  logic [31:0] memAddr,
    input  logic memAck
);

    int assertFails = 0;

    ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
        $rose(fetchAck) |-> fetchReq)
        else begin
            assertFails++;
            $error("fetchAck rose while fetchReq was low");
        end

    // refill goes to the aligned line of the fetch in flight
    memAddrLine: assert property (@(posedge clk) disable iff (rst)
        memReq |-> memAddr == {fetchAddr[31:4], 4'b0000})
        else begin
            assertFails++;
            $error("memAddr is not the aligned line address of the fetch");
        end

    memAddrStable: assert property (@(posedge clk) disable iff (rst)
        memReq && $past(memReq) |-> memAddr == $past(memAddr))
        else begin
            assertFails++;
            $error("memAddr changed while memReq was high");
        end

    memReqAfterAck: assert property (@(posedge clk) disable iff (rst)
        $rose(memReq) |-> !memAck)
        else begin
            assertFails++;
            $error("memReq rose before memAck had fallen");
        end

endmodule

// ==== bench/icacheTb.sv ====
`timescale 1ns/1ns

module icacheTb;

    typedef struct packed {
        logic [7:0] test;
        logic flushFirst;
        logic expectMiss;
        logic [31:0] addr;
    } rowT;

    localparam int Rows = 24;
    localparam int CycleLimit = Rows * 20 + 100;

    // test, flush first, miss expected, fetch address
    localparam rowT StimTable [Rows] = '{
        '{8'd1, 1'b0, 1'b1, 32'h0000_1008},
        '{8'd2, 1'b0, 1'b0, 32'h0000_1000},
        '{8'd2, 1'b0, 1'b0, 32'h0000_1004},
        '{8'd2, 1'b0, 1'b0, 32'h0000_100C},
        '{8'd2, 1'b0, 1'b0, 32'h0000_1008},
        // set 5 with tags 1 to 5
        '{8'd3, 1'b0, 1'b1, 32'h0000_0450},
        '{8'd3, 1'b0, 1'b1, 32'h0000_0850},
        '{8'd3, 1'b0, 1'b1, 32'h0000_0C50},
        '{8'd3, 1'b0, 1'b1, 32'h0000_1050},
        '{8'd3, 1'b0, 1'b0, 32'h0000_0454},
        '{8'd3, 1'b0, 1'b0, 32'h0000_0C58},
        '{8'd3, 1'b0, 1'b1, 32'h0000_1450},
        '{8'd3, 1'b0, 1'b0, 32'h0000_045C},
        '{8'd3, 1'b0, 1'b1, 32'h0000_0854},
        '{8'd3, 1'b0, 1'b0, 32'h0000_0C50},
        '{8'd3, 1'b0, 1'b1, 32'h0000_1058},
        '{8'd4, 1'b1, 1'b1, 32'h0000_1008},
        '{8'd4, 1'b0, 1'b0, 32'h0000_1000},
        '{8'd5, 1'b0, 1'b1, 32'h0002_0030},
        '{8'd5, 1'b0, 1'b0, 32'h0002_0034},
        '{8'd5, 1'b0, 1'b1, 32'h0003_FFF0},
        '{8'd5, 1'b0, 1'b1, 32'hFFFF_FFFC},
        '{8'd5, 1'b0, 1'b0, 32'h0003_FFF8},
        '{8'd5, 1'b0, 1'b0, 32'h0002_0038}
    };

    logic clk;
    logic rst;
    logic flush;
    logic fetchReq;
    logic [31:0] fetchAddr;
    logic fetchAck;
    logic [31:0] fetchData;
    logic memReq;
    logic [31:0] memAddr;
    logic memAck;
    logic [127:0] memLine;
    logic expectMiss;
    logic [7:0] testNum;
    logic testEnd;
    int checkErrors;
    int testCount;
    int testFailCount;
    int totalErrors;
    int cycleCount;
    integer seed = 42;

    icacheTop i_dut (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .fetchReq(fetchReq),
        .fetchAddr(fetchAddr),
        .fetchAck(fetchAck),
        .fetchData(fetchData),
        .memReq(memReq),
        .memAddr(memAddr),
        .memAck(memAck),
        .memLine(memLine)
    );

    icacheChecker i_checker (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .fetchReq(fetchReq),
        .fetchAddr(fetchAddr),
        .fetchAck(fetchAck),
        .fetchData(fetchData),
        .memReq(memReq),
        .memAddr(memAddr),
        .expectMiss(expectMiss),
        .testNum(testNum),
        .testEnd(testEnd),
        .errorCount(checkErrors),
        .testCount(testCount),
        .testFailCount(testFailCount)
    );

    bind icacheTop icacheProperties i_props (
        .clk(clk),
        .rst(rst),
        .fetchReq(fetchReq),
        .fetchAddr(fetchAddr),
        .fetchAck(fetchAck),
        .memReq(memReq),
        .memAddr(memAddr),
        .memAck(memAck)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [127:0] lineFor(input logic [31:0] a);
        logic [127:0] line;
        for (int i = 0; i < 4; i++) begin
            line[i*32 +: 32] = ({a[31:4], 4'b0000} + 32'(4 * i)) ^ 32'h5A5A0000;
        end
        return line;
    endfunction

    // memory side answers after 1 to 4 cycles
    initial begin
        int delay;
        logic [31:0] base;
        memAck = 1'b0;
        memLine = '0;
        forever begin
            do @(posedge clk); while (!memReq);
            base = memAddr;
            delay = 1 + int'($unsigned($random(seed)) % 4);
            repeat (delay - 1) @(posedge clk);
            #1;
            memLine = lineFor(base);
            memAck = 1'b1;
            do @(posedge clk); while (memReq);
            #1 memAck = 1'b0;
        end
    end

    task automatic runFetch(input logic [31:0] addr, input logic miss, input logic [7:0] test);
        @(posedge clk);
        #1;
        testNum = test;
        fetchAddr = addr;
        expectMiss = miss;
        fetchReq = 1'b1;
        do @(posedge clk); while (!fetchAck);
        #1 fetchReq = 1'b0;
        do @(posedge clk); while (fetchAck);
    endtask

    task automatic pulseFlush();
        @(posedge clk);
        #1 flush = 1'b1;
        @(posedge clk);
        #1 flush = 1'b0;
    endtask

    task automatic markTestEnd();
        #1 testEnd = 1'b1;
        @(posedge clk);
        #1 testEnd = 1'b0;
    endtask

    initial begin
        cycleCount = 0;
        while (cycleCount < CycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("the run timed out after %0d clock cycles", CycleLimit);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        rst = 1'b1;
        flush = 1'b0;
        fetchReq = 1'b0;
        fetchAddr = '0;
        expectMiss = 1'b0;
        testNum = '0;
        testEnd = 1'b0;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        repeat (3) @(posedge clk);
        for (int r = 0; r < Rows; r++) begin
            if (StimTable[r].flushFirst) begin
                pulseFlush();
            end
            runFetch(StimTable[r].addr, StimTable[r].expectMiss, StimTable[r].test);
            if (r == Rows - 1 || StimTable[r + 1].test != StimTable[r].test) begin
                markTestEnd();
            end
        end
        repeat (5) @(posedge clk);
        totalErrors = checkErrors + i_dut.i_props.assertFails;
        $display("tests %0d, passed %0d, failed %0d, check errors %0d, assertion failures %0d",
                 testCount, testCount - testFailCount, testFailCount, checkErrors,
                 i_dut.i_props.assertFails);
        if (totalErrors == 0 && testFailCount == 0 && testCount == 5) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== design/fetchControl.sv ====
`timescale 1ns/1ns

module fetchControl (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic fetchReq,
    input  logic [31:0] fetchAddr,
    output logic fetchAck,
    output logic memReq,
    output logic [31:0] memAddr,
    input  logic memAck,
    input  icachePkg::lineT memLine,
    input  logic hit,
    input  icachePkg::wayT hitWay,
    input  icachePkg::wayT victimWay,
    output logic lookupEn,
    output icachePkg::indexT lookupIndex,
    output icachePkg::tagT lookupTag,
    output logic fillEn,
    output icachePkg::indexT fillIndex,
    output icachePkg::tagT fillTag,
    output icachePkg::wayT fillWay,
    output icachePkg::lineT fillLine,
    output logic touchEn,
    output icachePkg::wayT touchWay,
    output icachePkg::indexT touchIndex,
    output logic [1:0] wordSel,
    output logic clearAll,
    output logic [31:0] fetchData,
    input  logic [31:0] readWord
);

    typedef enum logic [2:0] {
        stIdle,
        stLookup,
        stCompare,
        stMemWait,
        stMemRelease,
        stFill,
        stRespond,
        stRelease
    } stateT;

    stateT state;
    stateT nextState;
    icachePkg::fetchAddrU addrQ;
    icachePkg::fetchAddrU lineAddr;
    icachePkg::lineT lineQ;
    logic [31:0] dataQ;
    logic [31:0] lineWords [icachePkg::WordsPerLine];

    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                if (fetchReq) begin
                    nextState = stLookup;
                end
            end
            stLookup: begin
                nextState = stCompare;
            end
            stCompare: begin
                nextState = hit ? stRespond : stMemWait;
            end
            stMemWait: begin
                if (memAck) begin
                    nextState = stMemRelease;
                end
            end
            stMemRelease: begin
                if (!memAck) begin
                    nextState = stFill;
                end
            end
            stFill: begin
                nextState = stRespond;
            end
            stRespond: begin
                if (!fetchReq) begin
                    nextState = stRelease;
                end
            end
            default: begin
                nextState = stIdle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (state == stIdle && fetchReq) begin
            addrQ.raw <= fetchAddr;
        end
        if (state == stMemWait && memAck) begin
            lineQ <= memLine;
        end
        // a miss returns its word straight from the refill line
        if (state == stCompare && hit) begin
            dataQ <= readWord;
        end else if (state == stFill) begin
            dataQ <= lineWords[addrQ.fields.word];
        end
    end

    always_comb begin
        for (int i = 0; i < icachePkg::WordsPerLine; i++) begin
            lineWords[i] = lineQ[i*32 +: 32];
        end
    end

    always_comb begin
        lineAddr = addrQ;
        lineAddr.fields.word = '0;
        lineAddr.fields.byteSel = '0;
    end

    // ack stays up through release, so it drops one edge after req is seen low
    assign fetchAck = state == stRespond || state == stRelease;
    assign fetchData = dataQ;
    assign memReq = state == stMemWait;
    assign memAddr = lineAddr.raw;

    assign lookupEn = state == stLookup;
    assign lookupIndex = addrQ.fields.index;
    assign lookupTag = addrQ.fields.tag;
    assign wordSel = addrQ.fields.word;

    // tag, line and valid bit are written on the edge that sees memAck low
    assign fillEn = state == stMemRelease && !memAck;
    assign fillIndex = addrQ.fields.index;
    assign fillTag = addrQ.fields.tag;
    assign fillWay = victimWay;
    assign fillLine = lineQ;

    assign touchEn = (state == stCompare && hit) || fillEn;
    assign touchWay = fillEn ? victimWay : hitWay;
    assign touchIndex = addrQ.fields.index;

    // flush only counts when the CPU side is quiet
    assign clearAll = state == stIdle && flush && !fetchReq;

endmodule

// ==== design/icachePkg.sv ====
package icachePkg;

    // cache geometry, 4 ways x 64 sets x 16-byte lines
    localparam int WayCount = 4;
    localparam int SetCount = 64;
    localparam int WordsPerLine = 4;

    typedef logic [21:0] tagT;
    typedef logic [5:0] indexT;
    typedef logic [1:0] wayT;

    // tree age per set
    // bit 2 picks the way pair, bit 1 picks inside ways 2/3, bit 0 inside ways 0/1
    typedef logic [2:0] ageT;

    // word 0 sits in the low 32 bits
    typedef logic [WordsPerLine*32-1:0] lineT;

    // the fetch address, either as a plain byte address for the ports
    // or split up for indexing the arrays
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            tagT tag;
            indexT index;
            logic [1:0] word;
            logic [1:0] byteSel;
        } fields;
    } fetchAddrU;

endpackage

// ==== design/icacheTop.sv ====
`timescale 1ns/1ns

module icacheTop (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic fetchReq,
    input  logic [31:0] fetchAddr,
    output logic fetchAck,
    output logic [31:0] fetchData,
    output logic memReq,
    output logic [31:0] memAddr,
    input  logic memAck,
    input  icachePkg::lineT memLine
);

    logic lookupEn;
    icachePkg::indexT lookupIndex;
    icachePkg::tagT lookupTag;
    logic fillEn;
    icachePkg::indexT fillIndex;
    icachePkg::tagT fillTag;
    icachePkg::wayT fillWay;
    icachePkg::lineT fillLine;
    logic touchEn;
    icachePkg::wayT touchWay;
    icachePkg::indexT touchIndex;
    logic [1:0] wordSel;
    logic clearAll;
    logic hit;
    icachePkg::wayT hitWay;
    icachePkg::wayT victimWay;
    logic [icachePkg::WayCount-1:0] setValid;
    logic [31:0] readWord;

    fetchControl i_fetchControl (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .fetchReq(fetchReq),
        .fetchAddr(fetchAddr),
        .fetchAck(fetchAck),
        .memReq(memReq),
        .memAddr(memAddr),
        .memAck(memAck),
        .memLine(memLine),
        .hit(hit),
        .hitWay(hitWay),
        .victimWay(victimWay),
        .lookupEn(lookupEn),
        .lookupIndex(lookupIndex),
        .lookupTag(lookupTag),
        .fillEn(fillEn),
        .fillIndex(fillIndex),
        .fillTag(fillTag),
        .fillWay(fillWay),
        .fillLine(fillLine),
        .touchEn(touchEn),
        .touchWay(touchWay),
        .touchIndex(touchIndex),
        .wordSel(wordSel),
        .clearAll(clearAll),
        .fetchData(fetchData),
        .readWord(readWord)
    );

    tagStore i_tagStore (
        .clk(clk),
        .rst(rst),
        .lookupEn(lookupEn),
        .lookupIndex(lookupIndex),
        .lookupTag(lookupTag),
        .fillEn(fillEn),
        .fillIndex(fillIndex),
        .fillTag(fillTag),
        .fillWay(fillWay),
        .clearAll(clearAll),
        .hit(hit),
        .hitWay(hitWay),
        .setValid(setValid)
    );

    // line arrays share the lookup index with the tag arrays
    lineStore i_lineStore (
        .clk(clk),
        .readIndex(lookupIndex),
        .fillEn(fillEn),
        .fillIndex(fillIndex),
        .fillWay(fillWay),
        .fillLine(fillLine),
        .hitWay(hitWay),
        .wordSel(wordSel),
        .readWord(readWord)
    );

    plruAge i_plruAge (
        .clk(clk),
        .rst(rst),
        .clearAll(clearAll),
        .touchEn(touchEn),
        .touchIndex(touchIndex),
        .touchWay(touchWay),
        .setValid(setValid),
        .victimIndex(fillIndex),
        .victimWay(victimWay)
    );

endmodule

// ==== design/lineStore.sv ====
`timescale 1ns/1ns

module lineStore (
    input  logic clk,
    input  icachePkg::indexT readIndex,
    input  logic fillEn,
    input  icachePkg::indexT fillIndex,
    input  icachePkg::wayT fillWay,
    input  icachePkg::lineT fillLine,
    input  icachePkg::wayT hitWay,
    input  logic [1:0] wordSel,
    output logic [31:0] readWord
);

    icachePkg::lineT rdLine [icachePkg::WayCount];
    icachePkg::lineT hitLine;
    logic [31:0] words [icachePkg::WordsPerLine];

    for (genvar w = 0; w < icachePkg::WayCount; w++) begin : gWay
        icachePkg::lineT mem [icachePkg::SetCount];
        icachePkg::lineT rd;

        always_ff @(posedge clk) begin
            if (fillEn && fillWay == icachePkg::wayT'(w)) begin
                mem[fillIndex] <= fillLine;
            end
            rd <= mem[readIndex];
        end

        assign rdLine[w] = rd;
    end

    // hitWay comes out of the tag compare in the same cycle as rdLine
    assign hitLine = rdLine[hitWay];

    always_comb begin
        for (int i = 0; i < icachePkg::WordsPerLine; i++) begin
            words[i] = hitLine[i*32 +: 32];
        end
    end

    assign readWord = words[wordSel];

endmodule

// ==== design/plruAge.sv ====
`timescale 1ns/1ns

module plruAge (
    input  logic clk,
    input  logic rst,
    input  logic clearAll,
    input  logic touchEn,
    input  icachePkg::indexT touchIndex,
    input  icachePkg::wayT touchWay,
    input  logic [icachePkg::WayCount-1:0] setValid,
    input  icachePkg::indexT victimIndex,
    output icachePkg::wayT victimWay
);

    icachePkg::ageT age [icachePkg::SetCount];
    icachePkg::ageT cur;
    icachePkg::wayT fromAge;

    // each access points the tree away from the way just used
    always_ff @(posedge clk) begin
        if (rst || clearAll) begin
            for (int i = 0; i < icachePkg::SetCount; i++) begin
                age[i] <= '0;
            end
        end else if (touchEn) begin
            case (touchWay)
                2'd0: begin
                    age[touchIndex][2] <= 1'b1;
                    age[touchIndex][0] <= 1'b1;
                end
                2'd1: begin
                    age[touchIndex][2] <= 1'b1;
                    age[touchIndex][0] <= 1'b0;
                end
                2'd2: begin
                    age[touchIndex][2] <= 1'b0;
                    age[touchIndex][1] <= 1'b1;
                end
                default: begin
                    age[touchIndex][2] <= 1'b0;
                    age[touchIndex][1] <= 1'b0;
                end
            endcase
        end
    end

    assign cur = age[victimIndex];
    assign fromAge = cur[2] ? {1'b1, cur[1]} : {1'b0, cur[0]};

    // an empty way always beats the age tree
    always_comb begin
        victimWay = fromAge;
        for (int w = icachePkg::WayCount - 1; w >= 0; w--) begin
            if (!setValid[w]) begin
                victimWay = icachePkg::wayT'(w);
            end
        end
    end

endmodule

// ==== design/tagStore.sv ====
`timescale 1ns/1ns

module tagStore (
    input  logic clk,
    input  logic rst,
    input  logic lookupEn,
    input  icachePkg::indexT lookupIndex,
    input  icachePkg::tagT lookupTag,
    input  logic fillEn,
    input  icachePkg::indexT fillIndex,
    input  icachePkg::tagT fillTag,
    input  icachePkg::wayT fillWay,
    input  logic clearAll,
    output logic hit,
    output icachePkg::wayT hitWay,
    output logic [icachePkg::WayCount-1:0] setValid
);

    icachePkg::indexT indexQ;
    icachePkg::tagT tagQ;
    logic [icachePkg::WayCount-1:0] match;

    // lookup index and tag are held for the compare cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            indexQ <= '0;
        end else if (lookupEn) begin
            indexQ <= lookupIndex;
        end
    end

    always_ff @(posedge clk) begin
        if (lookupEn) begin
            tagQ <= lookupTag;
        end
    end

    for (genvar w = 0; w < icachePkg::WayCount; w++) begin : gWay
        icachePkg::tagT mem [icachePkg::SetCount];
        icachePkg::tagT rd;
        logic [icachePkg::SetCount-1:0] valid;

        always_ff @(posedge clk) begin
            if (fillEn && fillWay == icachePkg::wayT'(w)) begin
                mem[fillIndex] <= fillTag;
            end
            if (lookupEn) begin
                rd <= mem[lookupIndex];
            end
        end

        always_ff @(posedge clk) begin
            if (rst || clearAll) begin
                valid <= '0;
            end else if (fillEn && fillWay == icachePkg::wayT'(w)) begin
                valid[fillIndex] <= 1'b1;
            end
        end

        // live valid bits, so a fill shows up before the next lookup
        assign setValid[w] = valid[indexQ];
        assign match[w] = setValid[w] && rd == tagQ;
    end

    assign hit = |match;

    // lowest matching way wins
    always_comb begin
        hitWay = '0;
        for (int w = icachePkg::WayCount - 1; w >= 0; w--) begin
            if (match[w]) begin
                hitWay = icachePkg::wayT'(w);
            end
        end
    end

endmodule

// ==== icache.f ====
design/icachePkg.sv
design/tagStore.sv
design/lineStore.sv
design/plruAge.sv
design/fetchControl.sv
design/icacheTop.sv
bench/icacheProperties_properties.sv
bench/icacheChecker.sv
bench/icacheTb.sv
